/* Bender.yml */
package:
  name: ext_cpu_busses

export_include_dirs:
  - design

sources:
  - files:
      - design/ext_bus_pkg.sv
      - design/cpu_bus_capture.sv
      - design/ext_addr_decode.sv
      - design/ext_bus_sequencer.sv
      - design/ext_data_path.sv
      - design/ext_cpu_busses.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/ext_bus_checker.sv
      - tests/tb_ext_cpu_busses.sv

/* design/cpu_bus_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_capture (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               cpu_req,
	input  wire logic               cpu_wr,
	input  wire ext_bus_pkg::addr_t cpu_addr,
	input  wire ext_bus_pkg::data_t cpu_wdata,
	input  wire logic               dma_req,
	input  wire ext_bus_pkg::addr_t dma_addr,
	input  wire logic               seq_idle,
	output      logic               sel_valid,
	output      logic               sel_wr,
	output      logic               sel_dma,
	output      ext_bus_pkg::addr_t sel_addr,
	output      ext_bus_pkg::data_t sel_wdata
);

	logic               cpu_pend;
	logic               cpu_pend_wr;
	ext_bus_pkg::addr_t cpu_pend_addr;
	ext_bus_pkg::data_t cpu_pend_wdata;
	logic               dma_pend;
	ext_bus_pkg::addr_t dma_pend_addr;

	logic               cpu_have;
	logic               dma_have;
	logic               cpu_cur_wr;
	ext_bus_pkg::addr_t cpu_cur_addr;
	ext_bus_pkg::data_t cpu_cur_wdata;
	ext_bus_pkg::addr_t dma_cur_addr;
	logic               can_launch;
	logic               launch_cpu;
	logic               launch_dma;

	// A request arriving this cycle can launch straight away.
	assign cpu_have      = cpu_pend | cpu_req;
	assign dma_have      = dma_pend | dma_req;
	assign cpu_cur_wr    = cpu_req ? cpu_wr : cpu_pend_wr;
	assign cpu_cur_addr  = cpu_req ? cpu_addr : cpu_pend_addr;
	assign cpu_cur_wdata = cpu_req ? cpu_wdata : cpu_pend_wdata;
	assign dma_cur_addr  = dma_req ? dma_addr : dma_pend_addr;

	// sel_valid itself is still in flight when high, so block that cycle too.
	assign can_launch = seq_idle & ~sel_valid;
	assign launch_dma = can_launch & dma_have;                 // DMA has priority.
	assign launch_cpu = can_launch & ~dma_have & cpu_have;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cpu_pend  <= 1'b0;
			dma_pend  <= 1'b0;
			sel_valid <= 1'b0;
			sel_wr    <= 1'b0;
			sel_dma   <= 1'b0;
		end else begin
			cpu_pend  <= cpu_have & ~launch_cpu;
			dma_pend  <= dma_have & ~launch_dma;
			sel_valid <= launch_cpu | launch_dma;
			if (launch_dma) begin
				sel_wr  <= 1'b0;
				sel_dma <= 1'b1;
			end else if (launch_cpu) begin
				sel_wr  <= cpu_cur_wr;
				sel_dma <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_req) begin
			cpu_pend_wr    <= cpu_wr;
			cpu_pend_addr  <= cpu_addr;
			cpu_pend_wdata <= cpu_wdata;
		end
		if (dma_req)
			dma_pend_addr <= dma_addr;
		if (launch_dma) begin
			sel_addr  <= dma_cur_addr;
			sel_wdata <= '0;
		end else if (launch_cpu) begin
			sel_addr  <= cpu_cur_addr;
			sel_wdata <= cpu_cur_wdata;
		end
	end

endmodule

`default_nettype wire

/* design/ext_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_params.svh"

module ext_addr_decode (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               sel_valid,
	input  wire logic               sel_wr,
	input  wire logic               sel_dma,
	input  wire ext_bus_pkg::addr_t sel_addr,
	output      logic               dec_valid,
	output      logic               dec_ext,
	output      logic               dec_ram,
	output      logic               dec_wr,
	output      logic               dec_dma
);

	logic in_rom;
	logic in_ram;

	assign in_rom = (sel_addr <= `EXT_ROM_END);
	assign in_ram = (sel_addr >= `EXT_RAM_START) && (sel_addr <= `EXT_RAM_END);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= sel_valid;
		end
	end

	// Attributes stay put until the next access; the data path
	// still looks at dec_ext while the cycle completes.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dec_ext <= 1'b0;
			dec_ram <= 1'b0;
			dec_wr  <= 1'b0;
			dec_dma <= 1'b0;
		end else if (sel_valid) begin
			dec_ext <= in_rom | in_ram;    // Video and high page stay inside.
			dec_ram <= in_ram;
			dec_wr  <= sel_wr & ~sel_dma;  // DMA only reads.
			dec_dma <= sel_dma;
		end
	end

endmodule

`default_nettype wire

/* design/ext_bus_params.svh */
`ifndef EXT_BUS_PARAMS_SVH
`define EXT_BUS_PARAMS_SVH

// Cartridge ROM occupies the bottom half of the map.
`define EXT_ROM_END 16'h7FFF

// External work RAM window, chip select active in here.
`define EXT_RAM_START 16'hA000
`define EXT_RAM_END 16'hFDFF

// Length of the rd_n / wr_n low phase in clock cycles.
`define EXT_STROBE_CYCLES 2

// Value returned for reads that never reach the pins.
`define EXT_IDLE_DATA 8'hFF

`endif

/* design/ext_bus_pkg.sv */
`default_nettype none

package ext_bus_pkg;

	// Bus address, full 64K map.
	typedef logic [15:0] addr_t;

	// Data byte on the cartridge bus.
	typedef logic [7:0] data_t;

	// External cycle sequencer.
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_ADDR,   // Address out, cs_n low for RAM.
		SEQ_STROBE, // rd_n or wr_n low.
		SEQ_HOLD,   // Strobes released, access completes.
		SEQ_INT     // Internal region, no pins touched.
	} seq_state_e;

endpackage

`default_nettype wire

/* design/ext_bus_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_params.svh"

module ext_bus_sequencer (
	input  wire logic clk,
	input  wire logic arst_n,
	input  wire logic dec_valid,
	input  wire logic dec_ext,
	input  wire logic dec_ram,
	input  wire logic dec_wr,
	input  wire logic dec_dma,
	output      logic seq_idle,
	output      logic ext_cs_n,
	output      logic ext_rd_n,
	output      logic ext_wr_n,
	output      logic ext_d_oe,
	output      logic lat_rd,
	output      logic cpu_done,
	output      logic dma_done
);

	localparam int CNT_W = $clog2(`EXT_STROBE_CYCLES + 1);

	ext_bus_pkg::seq_state_e state;
	ext_bus_pkg::seq_state_e state_nxt;

	logic [CNT_W-1:0] strobe_cnt;
	logic             cyc_ram;
	logic             cyc_wr;
	logic             cyc_dma;
	logic             on_bus;
	logic             strobing;
	logic             strobe_last;
	logic             done;

	assign strobe_last = (strobe_cnt == '0);

	always_comb begin
		state_nxt = state;
		case (state)
			ext_bus_pkg::SEQ_IDLE: begin
				if (dec_valid)
					state_nxt = dec_ext ? ext_bus_pkg::SEQ_ADDR : ext_bus_pkg::SEQ_INT;
			end
			ext_bus_pkg::SEQ_ADDR:   state_nxt = ext_bus_pkg::SEQ_STROBE;
			ext_bus_pkg::SEQ_STROBE: begin
				if (strobe_last)
					state_nxt = ext_bus_pkg::SEQ_HOLD;
			end
			ext_bus_pkg::SEQ_HOLD:   state_nxt = ext_bus_pkg::SEQ_IDLE;
			ext_bus_pkg::SEQ_INT:    state_nxt = ext_bus_pkg::SEQ_IDLE;
			default:                 state_nxt = ext_bus_pkg::SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ext_bus_pkg::SEQ_IDLE;
			strobe_cnt <= '0;
		end else begin
			state <= state_nxt;
			if (state == ext_bus_pkg::SEQ_ADDR)
				strobe_cnt <= CNT_W'(`EXT_STROBE_CYCLES - 1);
			else if (state == ext_bus_pkg::SEQ_STROBE && !strobe_last)
				strobe_cnt <= strobe_cnt - 1'b1;
		end
	end

	// Owner of the cycle, taken when the decoder hands it over.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_ram <= 1'b0;
			cyc_wr  <= 1'b0;
			cyc_dma <= 1'b0;
		end else if (state == ext_bus_pkg::SEQ_IDLE && dec_valid) begin
			cyc_ram <= dec_ram;
			cyc_wr  <= dec_wr;
			cyc_dma <= dec_dma;
		end
	end

	assign on_bus   = (state == ext_bus_pkg::SEQ_ADDR) ||
	                  (state == ext_bus_pkg::SEQ_STROBE) ||
	                  (state == ext_bus_pkg::SEQ_HOLD);
	assign strobing = (state == ext_bus_pkg::SEQ_STROBE);

	assign ext_cs_n = ~(on_bus & cyc_ram);
	assign ext_rd_n = ~(strobing & ~cyc_wr);
	assign ext_wr_n = ~(strobing & cyc_wr);
	assign ext_d_oe = strobing & cyc_wr;              // Drive data only under wr_n.

	// Read data is sampled on the edge that ends the strobe.
	assign lat_rd = strobing & strobe_last & ~cyc_wr;

	assign done     = (state == ext_bus_pkg::SEQ_HOLD) || (state == ext_bus_pkg::SEQ_INT);
	assign cpu_done = done & ~cyc_dma;
	assign dma_done = done & cyc_dma;

	// Busy as soon as the decoder holds an access.
	assign seq_idle = (state == ext_bus_pkg::SEQ_IDLE) && !dec_valid;

endmodule

`default_nettype wire

/* design/ext_cpu_busses.sv */
`timescale 1ns/1ps
`default_nettype none

module ext_cpu_busses (
	input  wire logic               clk,
	input  wire logic               arst_n,

	input  wire logic               cpu_req,
	input  wire logic               cpu_wr,
	input  wire ext_bus_pkg::addr_t cpu_addr,
	input  wire ext_bus_pkg::data_t cpu_wdata,
	output      logic               cpu_done,
	output      ext_bus_pkg::data_t cpu_rdata,

	input  wire logic               dma_req,
	input  wire ext_bus_pkg::addr_t dma_addr,
	output      logic               dma_done,
	output      ext_bus_pkg::data_t dma_rdata,

	output      ext_bus_pkg::addr_t ext_a,
	output      logic               ext_cs_n,
	output      logic               ext_rd_n,
	output      logic               ext_wr_n,
	output      ext_bus_pkg::data_t ext_d_out,
	output      logic               ext_d_oe,
	input  wire ext_bus_pkg::data_t ext_d_in
);

	logic               sel_valid;
	logic               sel_wr;
	logic               sel_dma;
	ext_bus_pkg::addr_t sel_addr;
	ext_bus_pkg::data_t sel_wdata;
	logic               dec_valid;
	logic               dec_ext;
	logic               dec_ram;
	logic               dec_wr;
	logic               dec_dma;
	logic               seq_idle;
	logic               lat_rd;
	ext_bus_pkg::data_t rd_data;

	cpu_bus_capture u_capture (
		.clk, .arst_n,
		.cpu_req, .cpu_wr, .cpu_addr, .cpu_wdata,
		.dma_req, .dma_addr, .seq_idle,
		.sel_valid, .sel_wr, .sel_dma, .sel_addr, .sel_wdata
	);

	ext_addr_decode u_decode (
		.clk, .arst_n,
		.sel_valid, .sel_wr, .sel_dma, .sel_addr,
		.dec_valid, .dec_ext, .dec_ram, .dec_wr, .dec_dma
	);

	ext_bus_sequencer u_sequencer (
		.clk, .arst_n,
		.dec_valid, .dec_ext, .dec_ram, .dec_wr, .dec_dma,
		.seq_idle, .ext_cs_n, .ext_rd_n, .ext_wr_n, .ext_d_oe,
		.lat_rd, .cpu_done, .dma_done
	);

	ext_data_path u_data_path (
		.clk, .arst_n,
		.sel_valid, .sel_addr, .sel_wdata, .lat_rd, .dec_ext, .ext_d_in,
		.ext_a, .ext_d_out, .rd_data
	);

	// One read bus, qualified by the matching done pulse.
	assign cpu_rdata = rd_data;
	assign dma_rdata = rd_data;

endmodule

`default_nettype wire

/* design/ext_data_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_params.svh"

module ext_data_path (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               sel_valid,
	input  wire ext_bus_pkg::addr_t sel_addr,
	input  wire ext_bus_pkg::data_t sel_wdata,
	input  wire logic               lat_rd,
	input  wire logic               dec_ext,
	input  wire ext_bus_pkg::data_t ext_d_in,
	output      ext_bus_pkg::addr_t ext_a,
	output      ext_bus_pkg::data_t ext_d_out,
	output      ext_bus_pkg::data_t rd_data
);

	ext_bus_pkg::data_t rd_latch;

	// Address and write data are set up one cycle ahead of the
	// address phase and stay on the pins between accesses.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ext_a     <= '0;
			ext_d_out <= '0;
		end else if (sel_valid) begin
			ext_a     <= sel_addr;
			ext_d_out <= sel_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (lat_rd)
			rd_latch <= ext_d_in;   // Pins are still driven by the device here.
	end

	// Nothing answers in the internal regions.
	assign rd_data = dec_ext ? rd_latch : `EXT_IDLE_DATA;

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/ext_bus_pkg.sv
design/cpu_bus_capture.sv
design/ext_addr_decode.sv
design/ext_bus_sequencer.sv
design/ext_data_path.sv
design/ext_cpu_busses.sv
tests/ext_bus_checker.sv
tests/tb_ext_cpu_busses.sv

/* tests/ext_bus_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_params.svh"

module ext_bus_checker (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               cpu_req,
	input  wire logic               cpu_wr,
	input  wire ext_bus_pkg::addr_t cpu_addr,
	input  wire logic               cpu_done,
	input  wire ext_bus_pkg::data_t cpu_rdata,
	input  wire logic               dma_req,
	input  wire ext_bus_pkg::addr_t dma_addr,
	input  wire logic               dma_done,
	input  wire ext_bus_pkg::data_t dma_rdata,
	input  wire ext_bus_pkg::addr_t ext_a,
	input  wire logic               ext_cs_n,
	input  wire logic               ext_rd_n,
	input  wire logic               ext_wr_n,
	input  wire logic               ext_d_oe,
	input  wire logic [127:0]       cpu_name,
	input  wire logic [127:0]       dma_name,
	input  wire ext_bus_pkg::data_t cpu_exp,
	input  wire ext_bus_pkg::data_t dma_exp,
	output      int                 error_count,
	output      int                 check_count
);

	// Request edge to done covers capture, decode, address, strobe and hold.
	localparam int EXT_LATENCY = 4 + `EXT_STROBE_CYCLES;
	localparam int INT_LATENCY = 3;

	int                 cycle;
	int                 rst_edges;
	int                 cpu_start;
	int                 dma_start;
	logic               cpu_busy;
	logic               dma_busy;
	logic               cpu_wait;
	logic               dma_wait;
	logic               cpu_is_wr;
	ext_bus_pkg::addr_t cpu_req_addr;
	ext_bus_pkg::addr_t dma_req_addr;
	logic               seen_rd;
	logic               seen_wr;
	logic               seen_cs;
	logic               oe_missing;

	initial begin
		error_count = 0;
		check_count = 0;
		cycle       = 0;
		rst_edges   = 0;
		cpu_busy    = 1'b0;
		dma_busy    = 1'b0;
		seen_rd     = 1'b0;
		seen_wr     = 1'b0;
		seen_cs     = 1'b0;
		oe_missing  = 1'b0;
	end

	function automatic logic ram_addr(input ext_bus_pkg::addr_t a);
		return (a >= `EXT_RAM_START) && (a <= `EXT_RAM_END);
	endfunction

	function automatic logic external_addr(input ext_bus_pkg::addr_t a);
		return (a <= `EXT_ROM_END) || ram_addr(a);
	endfunction

	task automatic compare(input logic [127:0] name, input string what, input int exp,
		input int act, input logic as_hex);
		check_count++;
		if (exp != act) begin
			error_count++;
			if (as_hex)
				$display("Error: %0s %0s expected 0x%02h actual 0x%02h", name, what, exp, act);
			else
				$display("Error: %0s %0s expected %0d actual %0d", name, what, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		check_count++;
		error_count++;
		$display("%0s", msg);
	endtask

	// Strobe pattern of one finished access against its region.
	task automatic check_access(input logic [127:0] name, input logic wr,
		input ext_bus_pkg::addr_t addr, input logic rd_low, input logic wr_low,
		input logic cs_low, input logic oe_miss);
		compare(name, "rd_n low", external_addr(addr) && !wr, rd_low, 1'b0);
		compare(name, "wr_n low", external_addr(addr) && wr, wr_low, 1'b0);
		compare(name, "cs_n low", ram_addr(addr), cs_low, 1'b0);
		if (oe_miss)
			report_failure("Data output enable was low while wr_n was low.");
	endtask

	always @(posedge clk) begin : watch
		logic rd_now;
		logic wr_now;
		logic cs_now;
		logic oe_now;
		cycle = cycle + 1;
		if (!arst_n) begin
			rst_edges = rst_edges + 1;
			if (rst_edges > 1) begin            // First edge may still see X.
				compare("reset", "ext_cs_n", 1, ext_cs_n, 1'b0);
				compare("reset", "ext_rd_n", 1, ext_rd_n, 1'b0);
				compare("reset", "ext_wr_n", 1, ext_wr_n, 1'b0);
				compare("reset", "ext_d_oe", 0, ext_d_oe, 1'b0);
				compare("reset", "done", 0, cpu_done | dma_done, 1'b0);
				compare("reset", "ext_a", 0, ext_a, 1'b1);
			end
		end else begin
			rd_now = seen_rd | ~ext_rd_n;
			wr_now = seen_wr | ~ext_wr_n;
			cs_now = seen_cs | ~ext_cs_n;
			oe_now = oe_missing | (~ext_wr_n & ~ext_d_oe);
			if (dma_req) begin
				dma_busy     = 1'b1;
				dma_start    = cycle;
				dma_req_addr = dma_addr;
				dma_wait     = cpu_busy;
			end
			if (cpu_req) begin
				cpu_busy     = 1'b1;
				cpu_start    = cycle;
				cpu_req_addr = cpu_addr;
				cpu_is_wr    = cpu_wr;
				cpu_wait     = dma_busy;      // DMA goes first.
			end
			if (dma_done) begin
				if (!dma_busy) begin
					report_failure("dma_done pulsed with no DMA request outstanding.");
				end else begin
					if (!dma_wait)
						compare(dma_name, "latency", external_addr(dma_req_addr) ?
							EXT_LATENCY : INT_LATENCY, cycle - dma_start, 1'b0);
					compare(dma_name, "read data", dma_exp, dma_rdata, 1'b1);
					check_access(dma_name, 1'b0, dma_req_addr, rd_now, wr_now, cs_now, oe_now);
				end
				dma_busy = 1'b0;
			end
			if (cpu_done) begin
				if (!cpu_busy) begin
					report_failure("cpu_done pulsed with no CPU request outstanding.");
				end else begin
					if (cpu_wait && dma_busy)
						report_failure("cpu_done came before dma_done for requests made together.");
					if (!cpu_wait)
						compare(cpu_name, "latency", external_addr(cpu_req_addr) ?
							EXT_LATENCY : INT_LATENCY, cycle - cpu_start, 1'b0);
					if (!cpu_is_wr)
						compare(cpu_name, "read data", cpu_exp, cpu_rdata, 1'b1);
					check_access(cpu_name, cpu_is_wr, cpu_req_addr, rd_now, wr_now, cs_now,
						oe_now);
				end
				cpu_busy = 1'b0;
			end
			if (cpu_done || dma_done) begin
				seen_rd    = 1'b0;
				seen_wr    = 1'b0;
				seen_cs    = 1'b0;
				oe_missing = 1'b0;
			end else begin
				seen_rd    = rd_now;
				seen_wr    = wr_now;
				seen_cs    = cs_now;
				oe_missing = oe_now;
			end
		end
	end

endmodule

`default_nettype wire

/* tests/tb_ext_cpu_busses.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ext_cpu_busses;

	localparam int   N_TESTS        = 14;
	localparam int   TIMEOUT_CYCLES = N_TESTS * 12 + 50;
	localparam logic SRC_CPU        = 1'b0;
	localparam logic SRC_DMA        = 1'b1;

	logic               clk;
	logic               arst_n;
	logic               cpu_req;
	logic               cpu_wr;
	ext_bus_pkg::addr_t cpu_addr;
	ext_bus_pkg::data_t cpu_wdata;
	logic               cpu_done;
	ext_bus_pkg::data_t cpu_rdata;
	logic               dma_req;
	ext_bus_pkg::addr_t dma_addr;
	logic               dma_done;
	ext_bus_pkg::data_t dma_rdata;
	ext_bus_pkg::addr_t ext_a;
	logic               ext_cs_n;
	logic               ext_rd_n;
	logic               ext_wr_n;
	ext_bus_pkg::data_t ext_d_out;
	logic               ext_d_oe;
	ext_bus_pkg::data_t ext_d_in;

	logic [127:0]       cpu_name;
	logic [127:0]       dma_name;
	ext_bus_pkg::data_t cpu_exp;
	ext_bus_pkg::data_t dma_exp;
	int                 error_count;
	int                 check_count;
	int                 seed     = 28;
	int                 cycles   = 0;
	int                 n_loaded = 0;

	// One row per access; pair starts this row and the next one together.
	logic [127:0]       name_tab  [0:N_TESTS-1];
	logic               src_tab   [0:N_TESTS-1];
	logic               wr_tab    [0:N_TESTS-1];
	ext_bus_pkg::addr_t addr_tab  [0:N_TESTS-1];
	ext_bus_pkg::data_t wdata_tab [0:N_TESTS-1];
	ext_bus_pkg::data_t exp_tab   [0:N_TESTS-1];
	logic               pair_tab  [0:N_TESTS-1];

	logic [7:0]         ext_mem   [0:65535];

	ext_cpu_busses dut0 (
		.clk, .arst_n,
		.cpu_req, .cpu_wr, .cpu_addr, .cpu_wdata, .cpu_done, .cpu_rdata,
		.dma_req, .dma_addr, .dma_done, .dma_rdata,
		.ext_a, .ext_cs_n, .ext_rd_n, .ext_wr_n, .ext_d_out, .ext_d_oe, .ext_d_in
	);

	ext_bus_checker u_checker (
		.clk, .arst_n,
		.cpu_req, .cpu_wr, .cpu_addr, .cpu_done, .cpu_rdata,
		.dma_req, .dma_addr, .dma_done, .dma_rdata,
		.ext_a, .ext_cs_n, .ext_rd_n, .ext_wr_n, .ext_d_oe,
		.cpu_name, .dma_name, .cpu_exp, .dma_exp,
		.error_count, .check_count
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Cartridge side, preset so every byte depends on both address halves.
	initial begin : mem_fill
		int a;
		for (a = 0; a < 65536; a++)
			ext_mem[a] = a[7:0] ^ a[15:8];
	end

	assign ext_d_in = !ext_rd_n ? ext_mem[ext_a] : 8'h00;

	always @(posedge clk) begin
		if (!ext_wr_n)
			ext_mem[ext_a] <= ext_d_out;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: no done pulse after %0d cycles.", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("sim failed");
			$finish;
		end
	end

	task automatic add_entry(input logic [127:0] name, input logic src, input logic wr,
		input ext_bus_pkg::addr_t addr, input ext_bus_pkg::data_t wdata,
		input ext_bus_pkg::data_t exp, input logic pair);
		name_tab[n_loaded]  = name;
		src_tab[n_loaded]   = src;
		wr_tab[n_loaded]    = wr;
		addr_tab[n_loaded]  = addr;
		wdata_tab[n_loaded] = wdata;
		exp_tab[n_loaded]   = exp;
		pair_tab[n_loaded]  = pair;
		n_loaded++;
	endtask

	// Expected reads are low byte XOR high byte unless written or internal.
	task automatic load_table();
		add_entry("rom_read",      SRC_CPU, 1'b0, 16'h1234, 8'h00, 8'h26, 1'b0);
		add_entry("ram_write",     SRC_CPU, 1'b1, 16'hA010, 8'h5A, 8'h00, 1'b0);
		add_entry("ram_readback",  SRC_CPU, 1'b0, 16'hA010, 8'h00, 8'h5A, 1'b0);
		add_entry("video_read",    SRC_CPU, 1'b0, 16'h8800, 8'h00, 8'hFF, 1'b0);
		add_entry("high_read",     SRC_CPU, 1'b0, 16'hFF44, 8'h00, 8'hFF, 1'b0);
		add_entry("dma_read",      SRC_DMA, 1'b0, 16'h2345, 8'h00, 8'h66, 1'b0);
		add_entry("dma_first",     SRC_DMA, 1'b0, 16'h0F0F, 8'h00, 8'h00, 1'b1);
		add_entry("cpu_second",    SRC_CPU, 1'b0, 16'hA0C3, 8'h00, 8'h63, 1'b0);
		add_entry("ram_top_write", SRC_CPU, 1'b1, 16'hFDFF, 8'hC7, 8'h00, 1'b0);
		add_entry("dma_ram_read",  SRC_DMA, 1'b0, 16'hFDFF, 8'h00, 8'hC7, 1'b0);
		add_entry("rom_top",       SRC_CPU, 1'b0, 16'h7FFF, 8'h00, 8'h80, 1'b0);
		add_entry("dma_video",     SRC_DMA, 1'b0, 16'h9FFF, 8'h00, 8'hFF, 1'b0);
		add_entry("ram_bottom",    SRC_CPU, 1'b0, 16'hA000, 8'h00, 8'hA0, 1'b0);
		add_entry("high_page",     SRC_CPU, 1'b0, 16'hFE00, 8'h00, 8'hFF, 1'b0);
	endtask

	task automatic start_request(input int idx);
		if (src_tab[idx] == SRC_DMA) begin
			dma_req  <= 1'b1;
			dma_addr <= addr_tab[idx];
			dma_name <= name_tab[idx];
			dma_exp  <= exp_tab[idx];
		end else begin
			cpu_req   <= 1'b1;
			cpu_wr    <= wr_tab[idx];
			cpu_addr  <= addr_tab[idx];
			cpu_wdata <= wdata_tab[idx];
			cpu_name  <= name_tab[idx];
			cpu_exp   <= exp_tab[idx];
		end
	endtask

	task automatic wait_for_done(input logic want_cpu, input logic want_dma);
		logic got_cpu;
		logic got_dma;
		got_cpu = !want_cpu;
		got_dma = !want_dma;
		while (!(got_cpu && got_dma)) begin
			@(posedge clk);
			if (cpu_done)
				got_cpu = 1'b1;
			if (dma_done)
				got_dma = 1'b1;
		end
	endtask

	initial begin : run
		int   i;
		int   gap;
		logic want_cpu;
		logic want_dma;
		arst_n    = 1'b0;
		cpu_req   = 1'b0;
		cpu_wr    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		dma_req   = 1'b0;
		dma_addr  = '0;
		cpu_name  = "none";
		dma_name  = "none";
		cpu_exp   = '0;
		dma_exp   = '0;
		load_table();
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		i = 0;
		while (i < N_TESTS) begin
			@(posedge clk);
			start_request(i);
			want_cpu = (src_tab[i] == SRC_CPU);
			want_dma = (src_tab[i] == SRC_DMA);
			if (pair_tab[i]) begin                 // Both requesters in one cycle.
				start_request(i + 1);
				if (src_tab[i + 1] == SRC_CPU)
					want_cpu = 1'b1;
				else
					want_dma = 1'b1;
			end
			@(posedge clk);
			cpu_req <= 1'b0;
			dma_req <= 1'b0;
			wait_for_done(want_cpu, want_dma);
			i = i + (pair_tab[i] ? 2 : 1);
			gap = $unsigned($random(seed)) % 4;
			repeat (gap) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
